//--- Makefile
# Verilator build and run of the i/o block testbench

VERILATOR ?= verilator
TOP       ?= tb_centipede_io
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/centipede_io_top.sv
// top level of the i/o block: decoder, output latch, trakball axes, read mux, palette
`timescale 1ns/1ps
`default_nettype none

module centipede_io_top
   import centipede_pkg::*;
(
   input  logic               s_6mhz,
   input  logic               reset,
   input  bus_req_t           req_i,
   input  player_in_t         playerinput_i,
   input  logic [7:0]         trakball_i,
   input  logic [7:0]         joystick_i,
   input  logic [7:0]         sw1_i,
   input  logic [7:0]         sw2_i,
   input  logic               vblank_i,
   input  logic [1:0]         obj_i,
   input  logic [1:0]         area_i,
   output logic [DATA_W-1:0]  rdata_o,
   output logic [4:1]         led_o,
   output logic               flip_o,
   output logic [2:0]         coin_ctr_o,
   output logic [RGB_W-1:0]   rgb_o
);

   io_sel_t             sel;
   out_latch_t          latch;
   tb_axis_t            h_p1;
   tb_axis_t            h_p2;
   tb_axis_t            v_p1;
   tb_axis_t            v_p2;
   logic [TB_CNT_W-1:0] h_count;
   logic [TB_CNT_W-1:0] v_count;
   logic                h_dir;
   logic                v_dir;
   logic                color_we;
   logic [COLOR_W-1:0]  color_rd;

   // trakball pins: 7/6 horiz dir p1/p2, 5/4 horiz ck, 3/2 vert dir, 1/0 vert ck
   assign h_p1 = '{dir: trakball_i[7], ck: trakball_i[5]};
   assign h_p2 = '{dir: trakball_i[6], ck: trakball_i[4]};
   assign v_p1 = '{dir: trakball_i[3], ck: trakball_i[1]};
   assign v_p2 = '{dir: trakball_i[2], ck: trakball_i[0]};

   io_addr_decode u_decode (
      .req_i (req_i),
      .sel_o (sel)
   );

   coin_led_latch u_latch (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .sel_i      (sel),
      .bit_addr_i (req_i.addr[2:0]),
      .wdata7_i   (req_i.wdata[7]),
      .latch_o    (latch)
   );

   // horizontal axis
   trakball_axis u_tb_h (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .p1_i        (h_p1),
      .p2_i        (h_p2),
      .flip_i      (latch.flip),
      .steer_clr_i (sel.steer_clr),
      .count_o     (h_count),
      .dir_o       (h_dir)
   );

   // vertical axis
   trakball_axis u_tb_v (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .p1_i        (v_p1),
      .p2_i        (v_p2),
      .flip_i      (latch.flip),
      .steer_clr_i (sel.steer_clr),
      .count_o     (v_count),
      .dir_o       (v_dir)
   );

   io_read_mux u_rd_mux (
      .s_6mhz     (s_6mhz),
      .reset      (reset),
      .rd_i       (req_i.rd),
      .sel_i      (sel),
      .player_i   (playerinput_i),
      .joystick_i (joystick_i),
      .sw1_i      (sw1_i),
      .sw2_i      (sw2_i),
      .vblank_i   (vblank_i),
      .latch_i    (latch),
      .h_count_i  (h_count),
      .v_count_i  (v_count),
      .h_dir_i    (h_dir),
      .v_dir_i    (v_dir),
      .color_rd_i (color_rd),
      .rdata_o    (rdata_o)
   );

   // colour write strobe
   assign color_we = sel.color_sel & req_i.wr;

   color_palette u_palette (
      .s_6mhz      (s_6mhz),
      .reset       (reset),
      .color_we_i  (color_we),
      .addr_i      (req_i.addr[COLOR_AW-1:0]),
      .wdata_i     (req_i.wdata[COLOR_W-1:0]),
      .obj_i       (obj_i),
      .area_i      (area_i),
      .cpu_rdata_o (color_rd),
      .rgb_o       (rgb_o)
   );

   assign led_o      = latch.led;
   assign flip_o     = latch.flip;
   assign coin_ctr_o = {latch.coin_r_drv, latch.coin_c_drv, latch.coin_l_drv};

endmodule

`default_nettype wire

//--- design/centipede_pkg.sv
// bus widths, region codes, bus and i/o struct types, palette function
`default_nettype none

package centipede_pkg;

   // cpu bus
   localparam int ADDR_W     = 14;
   localparam int DATA_W     = 8;

   // region field sits in address bits 13..10
   localparam int REGION_LSB = 10;
   localparam int REGION_W   = 4;

   // region codes kept from the original decoder
   localparam logic [REGION_W-1:0] REG_SWITCH   = 4'd2;
   localparam logic [REGION_W-1:0] REG_INPUT    = 4'd3;
   localparam logic [REGION_W-1:0] REG_COLOR    = 4'd5;
   localparam logic [REGION_W-1:0] REG_OUTLATCH = 4'd7;
   localparam logic [REGION_W-1:0] REG_STEERCLR = 4'd9;

   // address bit 9 high in the colour region is the dropped ea-rom half
   localparam int EA_BIT     = 9;

   // trakball counters
   localparam int TB_CNT_W   = 4;

   // colour ram and video output
   localparam int COLOR_W     = 4;
   localparam int COLOR_DEPTH = 16;
   localparam int COLOR_AW    = $clog2(COLOR_DEPTH);
   localparam int RGB_W       = 9;
   localparam int CH_W        = 3;

   // video index bases, motion objects at 12..15, playfield at 4..7
   localparam logic [COLOR_AW-1:0] OBJ_BASE = 4'd12;
   localparam logic [COLOR_AW-1:0] PF_BASE  = 4'd4;

   // channel levels for a set rgbi bit
   localparam logic [CH_W-1:0] SHADE_DIM = 3'b011;
   localparam logic [CH_W-1:0] SHADE_OFF = 3'b000;

   // cpu request, one-cycle strobes
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              rd;
      logic              wr;
   } bus_req_t;

   // decoded region selects plus bank bits a1 a0
   typedef struct packed {
      logic       switch_rd;
      logic       input_rd;
      logic       color_sel;
      logic       outlatch_wr;
      logic       steer_clr;
      logic [1:0] bank;
   } io_sel_t;

   // one player's trakball channel
   typedef struct packed {
      logic dir;
      logic ck;
   } tb_axis_t;

   // same bit order as the playerinput pins, coin_r at bit 9
   typedef struct packed {
      logic coin_r;
      logic coin_c;
      logic coin_l;
      logic self_test;
      logic cocktail;
      logic slam;
      logic start1;
      logic start2;
      logic fire2;
      logic fire1;
   } player_in_t;

   // addressable output latch, flip at bit 7
   typedef struct packed {
      logic       flip;
      logic [4:1] led;
      logic       coin_r_drv;
      logic       coin_c_drv;
      logic       coin_l_drv;
   } out_latch_t;

   // rgbi to 3-3-3 rgb, bit 2 red, bit 1 green, bit 0 blue
   // bit 3 picks between dim and off for the set channels
   function automatic logic [RGB_W-1:0] rgbi_to_rgb(input logic [COLOR_W-1:0] rgbi);
      logic [CH_W-1:0]  shade;
      logic [RGB_W-1:0] rgb;
      shade = rgbi[3] ? SHADE_OFF : SHADE_DIM;
      rgb   = '1;
      for (int ch = 0; ch < 3; ch++)
      begin
         // clear bit leaves the channel at full level
         if (rgbi[ch])
            rgb[ch*CH_W +: CH_W] = shade;
      end
      return rgb;
   endfunction

endpackage

`default_nettype wire

//--- design/coin_led_latch.sv
// addressable coin counter, led and flip output latch
`timescale 1ns/1ps
`default_nettype none

module coin_led_latch
   import centipede_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  io_sel_t    sel_i,
   input  logic [2:0] bit_addr_i,
   input  logic       wdata7_i,
   output out_latch_t latch_o
);

   logic [7:0] latch_q;

   // one bit per write, index from a2..a0, value from d7
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         latch_q <= '0;
      end
      else if (sel_i.outlatch_wr)
      begin
         latch_q[bit_addr_i] <= wdata7_i;
      end
   end

   // bit 7 flip, 6..3 leds, 2..0 coin counters r c l
   assign latch_o = out_latch_t'(latch_q);

endmodule

`default_nettype wire

//--- design/color_palette.sv
// colour ram with cpu and video ports, video index select, rgbi register, rgb expansion
`timescale 1ns/1ps
`default_nettype none

module color_palette
   import centipede_pkg::*;
(
   input  logic                s_6mhz,
   input  logic                reset,
   input  logic                color_we_i,
   input  logic [COLOR_AW-1:0] addr_i,
   input  logic [COLOR_W-1:0]  wdata_i,
   input  logic [1:0]          obj_i,
   input  logic [1:0]          area_i,
   output logic [COLOR_W-1:0]  cpu_rdata_o,
   output logic [RGB_W-1:0]    rgb_o
);

   logic [COLOR_W-1:0]  color_ram [COLOR_DEPTH];
   logic [COLOR_AW-1:0] vid_idx;
   logic [COLOR_W-1:0]  rgbi_q;

   // cpu write port
   always_ff @(posedge s_6mhz)
   begin
      if (color_we_i)
         color_ram[addr_i] <= wdata_i;
   end

   // cpu read-back, registered later in the read mux
   assign cpu_rdata_o = color_ram[addr_i];

   // motion object colours take priority over playfield
   always_comb
   begin
      if (obj_i != 2'b00)
         vid_idx = OBJ_BASE + COLOR_AW'(obj_i);
      else
         vid_idx = PF_BASE + COLOR_AW'(area_i);
   end

   // video read sees the ram before any write on the same edge
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         rgbi_q <= '0;
      else
         rgbi_q <= color_ram[vid_idx];
   end

   // rgbi of zero gives white, so reset shows all ones
   assign rgb_o = rgbi_to_rgb(rgbi_q);

endmodule

`default_nettype wire

//--- design/io_addr_decode.sv
// region decoder for the cpu i/o space, read and write select generation
`timescale 1ns/1ps
`default_nettype none

module io_addr_decode
   import centipede_pkg::*;
(
   input  bus_req_t req_i,
   output io_sel_t  sel_o
);

   logic [REGION_W-1:0] region;
   logic                hit_switch;
   logic                hit_input;
   logic                hit_color;
   logic                hit_outlatch;
   logic                hit_steerclr;

   // region field, a13..a10
   assign region = req_i.addr[REGION_LSB +: REGION_W];

   // raw region hits
   assign hit_switch   = (region == REG_SWITCH);
   assign hit_input    = (region == REG_INPUT);
   assign hit_outlatch = (region == REG_OUTLATCH);
   assign hit_steerclr = (region == REG_STEERCLR);

   // colour ram is the lower half, a9 high was the ea-rom
   assign hit_color    = (region == REG_COLOR) && !req_i.addr[EA_BIT];

   // read selects
   assign sel_o.switch_rd   = hit_switch & req_i.rd;
   assign sel_o.input_rd    = hit_input & req_i.rd;

   // colour select serves both directions, so it stays unqualified
   assign sel_o.color_sel   = hit_color;

   // write selects
   assign sel_o.outlatch_wr = hit_outlatch & req_i.wr;
   assign sel_o.steer_clr   = hit_steerclr & req_i.wr;

   // bank bits pick the word inside the input and switch regions
   assign sel_o.bank        = req_i.addr[1:0];

endmodule

`default_nettype wire

//--- design/io_read_mux.sv
// input word assembly and registered cpu read data
`timescale 1ns/1ps
`default_nettype none

module io_read_mux
   import centipede_pkg::*;
(
   input  logic                s_6mhz,
   input  logic                reset,
   input  logic                rd_i,
   input  io_sel_t             sel_i,
   input  player_in_t          player_i,
   input  logic [7:0]          joystick_i,
   input  logic [7:0]          sw1_i,
   input  logic [7:0]          sw2_i,
   input  logic                vblank_i,
   input  out_latch_t          latch_i,
   input  logic [TB_CNT_W-1:0] h_count_i,
   input  logic [TB_CNT_W-1:0] v_count_i,
   input  logic                h_dir_i,
   input  logic                v_dir_i,
   input  logic [COLOR_W-1:0]  color_rd_i,
   output logic [DATA_W-1:0]   rdata_o
);

   logic              coin_r;
   logic              coin_c;
   logic              coin_l;
   logic [DATA_W-1:0] in0_word;
   logic [DATA_W-1:0] in1_word;
   logic [DATA_W-1:0] tb_h_word;
   logic [DATA_W-1:0] tb_v_word;
   logic [DATA_W-1:0] rd_word;

   // a driven coin counter reads back as an active coin
   assign coin_r = player_i.coin_r | latch_i.coin_r_drv;
   assign coin_c = player_i.coin_c | latch_i.coin_c_drv;
   assign coin_l = player_i.coin_l | latch_i.coin_l_drv;

   // a1=0 a0=1, coins and buttons
   assign in0_word  = {coin_r, coin_c, coin_l, player_i.slam,
                       player_i.fire2, player_i.fire1, player_i.start1, player_i.start2};

   // a1=0 a0=0, horizontal trakball with vblank and cabinet bits
   assign tb_h_word = {h_dir_i, vblank_i, player_i.self_test, player_i.cocktail, h_count_i};

   // a1=1 a0=1, both joysticks
   assign in1_word  = joystick_i;

   // a1=1 a0=0, vertical trakball, gap bits read low
   assign tb_v_word = {v_dir_i, {(DATA_W-TB_CNT_W-1){1'b0}}, v_count_i};

   // word select, unmapped regions fall through to zero
   always_comb
   begin
      rd_word = '0;
      if (sel_i.input_rd)
      begin
         case (sel_i.bank)
            2'b00:   rd_word = tb_h_word;
            2'b01:   rd_word = in0_word;
            2'b10:   rd_word = tb_v_word;
            default: rd_word = in1_word;
         endcase
      end
      else if (sel_i.switch_rd)
         rd_word = sel_i.bank[0] ? sw2_i : sw1_i;
      else if (sel_i.color_sel)
         rd_word = {{(DATA_W-COLOR_W){1'b0}}, color_rd_i};
   end

   // read data holds until the next read strobe
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         rdata_o <= '0;
      else if (rd_i)
         rdata_o <= rd_word;
   end

endmodule

`default_nettype wire

//--- design/trakball_axis.sv
// one trakball axis: player select, ck synchroniser, direction latch, up/down counter
`timescale 1ns/1ps
`default_nettype none

module trakball_axis
   import centipede_pkg::*;
(
   input  logic                s_6mhz,
   input  logic                reset,
   input  tb_axis_t            p1_i,
   input  tb_axis_t            p2_i,
   input  logic                flip_i,
   input  logic                steer_clr_i,
   output logic [TB_CNT_W-1:0] count_o,
   output logic                dir_o
);

   tb_axis_t            chan;
   tb_axis_t            sync1_q;
   tb_axis_t            sync2_q;
   logic                ck_prev_q;
   logic                step;
   logic                dir_q;
   logic [TB_CNT_W-1:0] count_q;

   // flip high reads player 1, low reads player 2 (cocktail)
   assign chan = flip_i ? p1_i : p2_i;

   // dir rides along with ck so both stay aligned through the flops
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         sync1_q   <= '0;
         sync2_q   <= '0;
         ck_prev_q <= 1'b0;
      end
      else
      begin
         sync1_q   <= chan;
         sync2_q   <= sync1_q;
         ck_prev_q <= sync2_q.ck;
      end
   end

   // rising edge of the synchronised ck
   assign step = sync2_q.ck & ~ck_prev_q;

   // direction latched on each step
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         dir_q <= 1'b0;
      else if (step)
         dir_q <= sync2_q.dir;
   end

   // steer clear wins over a step, count wraps mod 16
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         count_q <= '0;
      else if (steer_clr_i)
         count_q <= '0;
      else if (step)
         count_q <= sync2_q.dir ? count_q + TB_CNT_W'(1) : count_q - TB_CNT_W'(1);
   end

   assign count_o = count_q;
   assign dir_o   = dir_q;

endmodule

`default_nettype wire

//--- flist.f
design/centipede_pkg.sv
design/io_addr_decode.sv
design/coin_led_latch.sv
design/trakball_axis.sv
design/io_read_mux.sv
design/color_palette.sv
design/centipede_io_top.sv
verif/centipede_io_sva.sv
verif/tb_centipede_io.sv

//--- verif/centipede_io_golden.txt
# op addr data expect, hex; R read, S read of random switch/joystick, L latch write
# W write, I player pins (addr) vblank (data), T dir pins/ck mask/pulses, V video obj,area
R 0000 00 00
L 1c03 80 08
L 1c02 80 0c
L 1c03 00 04
R 0c01 00 80
I 0155 01 00
R 0c01 00 d5
R 0c00 00 60
L 1c02 00 00
S 0800 00 00
S 0801 00 00
S 0c03 00 00
R 1600 00 00
T 0040 10 05
R 0c00 00 e5
T 0000 01 03
R 0c02 00 0d
L 1c07 80 80
T 0000 20 02
R 0c00 00 63
W 2400 00 00
R 0c00 00 60
R 0c02 00 00
W 1405 0b 00
W 140e 06 00
R 1405 00 0b
V 0001 00 1c0
V 0008 00 0df

//--- verif/centipede_io_sva.sv
// bound assertions on the i/o top level: reset values, strobe exclusion, known rgb
`timescale 1ns/1ps
`default_nettype none

module centipede_io_sva
   import centipede_pkg::*;
(
   input logic              s_6mhz,
   input logic              reset,
   input bus_req_t          req_i,
   input logic [4:1]        led_o,
   input logic [DATA_W-1:0] rdata_o,
   input logic [RGB_W-1:0]  rgb_o
);

   // failures seen so far, read by the testbench at the end
   int fail_count = 0;

   // first edge out of reset still sees cleared leds and read data
   a_reset_values: assert property (@(posedge s_6mhz)
      $fell(reset) |-> (led_o == '0 && rdata_o == '0))
   else
   begin
      fail_count++;
      $error("led_o or rdata_o not zero after reset");
   end

   // cpu issues a read or a write, never both
   a_one_strobe: assert property (@(posedge s_6mhz) disable iff (reset)
      !(req_i.rd && req_i.wr))
   else
   begin
      fail_count++;
      $error("rd and wr high in the same cycle");
   end

   // palette output always driven from a written entry
   a_rgb_known: assert property (@(posedge s_6mhz) disable iff (reset)
      !$isunknown(rgb_o))
   else
   begin
      fail_count++;
      $error("rgb_o has unknown bits");
   end

endmodule

bind centipede_io_top centipede_io_sva u_sva (
   .s_6mhz  (s_6mhz),
   .reset   (reset),
   .req_i   (req_i),
   .led_o   (led_o),
   .rdata_o (rdata_o),
   .rgb_o   (rgb_o)
);

`default_nettype wire

//--- verif/tb_centipede_io.sv
// testbench for the i/o block: clock, reset, golden-file stimulus, compare tasks, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_centipede_io
   import centipede_pkg::*;
();

   localparam int    CLK_NS      = 100;
   localparam int    RESET_CYC   = 8;
   localparam string GOLDEN_FILE = "verif/centipede_io_golden.txt";

   logic               s_6mhz;
   logic               reset;
   bus_req_t           req;
   player_in_t         playerinput;
   logic [7:0]         trakball;
   logic [7:0]         joystick;
   logic [7:0]         sw1;
   logic [7:0]         sw2;
   logic               vblank;
   logic [1:0]         obj;
   logic [1:0]         area;
   logic [DATA_W-1:0]  rdata;
   logic [4:1]         led;
   logic               flip;
   logic [2:0]         coin_ctr;
   logic [RGB_W-1:0]   rgb;

   // golden records, one entry per line of the data file
   logic [7:0]         op_q [$];
   logic [15:0]        addr_q [$];
   logic [15:0]        data_q [$];
   logic [15:0]        exp_q [$];

   // colour ram contents as written over the bus
   logic [COLOR_W-1:0] color_model [COLOR_DEPTH];

   int                 seed = 40;
   int                 value_errors = 0;
   int                 other_errors = 0;
   logic               loaded = 1'b0;

   centipede_io_top UUT (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .req_i         (req),
      .playerinput_i (playerinput),
      .trakball_i    (trakball),
      .joystick_i    (joystick),
      .sw1_i         (sw1),
      .sw2_i         (sw2),
      .vblank_i      (vblank),
      .obj_i         (obj),
      .area_i        (area),
      .rdata_o       (rdata),
      .led_o         (led),
      .flip_o        (flip),
      .coin_ctr_o    (coin_ctr),
      .rgb_o         (rgb)
   );

   // 100 ns clock
   initial
   begin
      s_6mhz = 1'b0;
      forever #(CLK_NS / 2) s_6mhz = ~s_6mhz;
   end

   task automatic check_byte(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("Error: %s expected %h got %h at %0t", name, exp, got, $time);
      end
   endtask

   task automatic check_latch(input out_latch_t got, input out_latch_t exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("Error: latch {flip_o,led_o,coin_ctr_o} expected %h got %h at %0t",
                  exp, got, $time);
      end
   endtask

   task automatic check_rgb(input logic [RGB_W-1:0] got, input logic [RGB_W-1:0] exp);
      if (got !== exp)
      begin
         value_errors++;
         $display("Error: rgb_o expected %h got %h at %0t", exp, got, $time);
      end
   endtask

   // palette rule: clear bit gives full level, set bit dim or off by bit 3
   function automatic logic [RGB_W-1:0] expand_rgbi(input logic [COLOR_W-1:0] rgbi);
      logic [2:0] lvl;
      logic [2:0] red;
      logic [2:0] green;
      logic [2:0] blue;
      lvl   = rgbi[3] ? SHADE_OFF : SHADE_DIM;
      red   = rgbi[2] ? lvl : 3'b111;
      green = rgbi[1] ? lvl : 3'b111;
      blue  = rgbi[0] ? lvl : 3'b111;
      return {red, green, blue};
   endfunction

   // objects use entries 12..15, playfield 4..7
   function automatic logic [3:0] video_index(input logic [1:0] o, input logic [1:0] a);
      return (o != 2'b00) ? 4'd12 + {2'b00, o} : 4'd4 + {2'b00, a};
   endfunction

   // preload pattern, every address bit matters
   function automatic logic [COLOR_W-1:0] fill_value(input logic [3:0] idx);
      return {idx[0], idx[3:1]} ^ 4'ha;
   endfunction

   // expected word for ports driven from the random switch and joystick values
   function automatic logic [DATA_W-1:0] random_port_word(input logic [15:0] a);
      if (a[13:10] == REG_SWITCH)
         return a[0] ? sw2 : sw1;
      else if (a[13:10] == REG_INPUT && a[1:0] == 2'b11)
         return joystick;
      return '0;
   endfunction

   task automatic load_golden();
      int          fd;
      int          c;
      int          n;
      logic [7:0]  ch;
      logic [15:0] a;
      logic [15:0] d;
      logic [15:0] e;
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0)
      begin
         other_errors++;
         $display("Could not open the golden file %s", GOLDEN_FILE);
      end
      else
      begin
         c = $fgetc(fd);
         while (c != -1)
         begin
            ch = 8'(c);
            // comment lines run to the newline
            if (ch == "#")
            begin
               while (c != -1 && 8'(c) != "\n")
                  c = $fgetc(fd);
            end
            else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t")
            begin
               n = $fscanf(fd, "%h %h %h", a, d, e);
               if (n == 3)
               begin
                  op_q.push_back(ch);
                  addr_q.push_back(a);
                  data_q.push_back(d);
                  exp_q.push_back(e);
               end
               else
               begin
                  other_errors++;
                  $display("Golden record %0d is malformed", op_q.size());
               end
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
      end
   endtask

   // one-cycle write strobe, result visible from the next cycle
   task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
      @(posedge s_6mhz);
      req.addr  <= a;
      req.wdata <= d;
      req.wr    <= 1'b1;
      @(posedge s_6mhz);
      req.wr    <= 1'b0;
      @(negedge s_6mhz);
   endtask

   // one-cycle read strobe, rdata_o registered on the strobe edge
   task automatic bus_read(input logic [ADDR_W-1:0] a);
      @(posedge s_6mhz);
      req.addr <= a;
      req.rd   <= 1'b1;
      @(posedge s_6mhz);
      req.rd   <= 1'b0;
      @(negedge s_6mhz);
   endtask

   // dir pins held, ck pins toggled n times, then the fixed settle time
   task automatic pulse_trakball(input logic [7:0] pins, input logic [7:0] mask,
                                 input logic [4:0] n);
      @(posedge s_6mhz);
      trakball <= pins;
      repeat (n)
      begin
         @(posedge s_6mhz);
         trakball <= pins | mask;
         @(posedge s_6mhz);
         trakball <= pins;
      end
      repeat (4) @(posedge s_6mhz);
   endtask

   // rgb follows one edge after obj and area are sampled
   task automatic show_video(input logic [1:0] o, input logic [1:0] a);
      @(posedge s_6mhz);
      obj  <= o;
      area <= a;
      @(posedge s_6mhz);
      @(negedge s_6mhz);
   endtask

   task automatic run_record(input int k);
      logic [7:0]       op;
      logic [15:0]      a;
      logic [15:0]      d;
      logic [15:0]      e;
      logic [RGB_W-1:0] want_rgb;
      op = op_q[k];
      a  = addr_q[k];
      d  = data_q[k];
      e  = exp_q[k];
      case (op)
         "R":
         begin
            bus_read(a[ADDR_W-1:0]);
            check_byte("rdata_o", rdata, e[DATA_W-1:0]);
         end
         "S":
         begin
            bus_read(a[ADDR_W-1:0]);
            check_byte("rdata_o", rdata, random_port_word(a));
         end
         "L":
         begin
            bus_write(a[ADDR_W-1:0], d[DATA_W-1:0]);
            check_latch(out_latch_t'({flip, led, coin_ctr}), out_latch_t'(e[7:0]));
         end
         "W":
         begin
            bus_write(a[ADDR_W-1:0], d[DATA_W-1:0]);
            // colour ram is the lower half of region 5
            if (a[13:10] == REG_COLOR && !a[9])
               color_model[a[3:0]] = d[3:0];
         end
         "I":
         begin
            @(posedge s_6mhz);
            playerinput <= player_in_t'(a[9:0]);
            vblank      <= d[0];
         end
         "T":
            pulse_trakball(a[7:0], d[7:0], e[4:0]);
         "V":
         begin
            want_rgb = expand_rgbi(color_model[video_index(a[3:2], a[1:0])]);
            if (e[RGB_W-1:0] !== want_rgb)
            begin
               other_errors++;
               $display("Golden record %0d gives a video value off the palette rule", k);
            end
            show_video(a[3:2], a[1:0]);
            check_rgb(rgb, want_rgb);
         end
         default:
         begin
            other_errors++;
            $display("Golden record %0d has an unknown operation", k);
         end
      endcase
   endtask

   task automatic report_counts();
      $display("value errors: %0d, other errors: %0d, assertion failures: %0d",
               value_errors, other_errors, UUT.u_sva.fail_count);
   endtask

   initial
   begin
      logic [3:0] idx;
      reset       <= 1'b1;
      req         <= '0;
      playerinput <= '0;
      trakball    <= '0;
      joystick    <= 8'($random(seed));
      sw1         <= 8'($random(seed));
      sw2         <= 8'($random(seed));
      vblank      <= 1'b0;
      obj         <= 2'b00;
      area        <= 2'b00;
      load_golden();
      loaded = 1'b1;
      // reset cycles also preload the video entries 4..7 and 12..15
      for (int i = 0; i < RESET_CYC; i++)
      begin
         @(posedge s_6mhz);
         idx = (i < 4) ? 4'(4 + i) : 4'(8 + i);
         req.addr  <= {REG_COLOR, 6'b000000, idx};
         req.wdata <= {4'h0, fill_value(idx)};
         req.wr    <= 1'b1;
         color_model[idx] = fill_value(idx);
      end
      // reset state, still held
      @(negedge s_6mhz);
      check_latch(out_latch_t'({flip, led, coin_ctr}), '0);
      check_rgb(rgb, '1);
      check_byte("rdata_o", rdata, '0);
      @(posedge s_6mhz);
      reset  <= 1'b0;
      req.wr <= 1'b0;
      foreach (op_q[k])
         run_record(k);
      repeat (2) @(posedge s_6mhz);
      report_counts();
      if (value_errors + other_errors + UUT.u_sva.fail_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

   // watchdog, 64 clocks per record plus margin
   initial
   begin
      wait (loaded);
      #(CLK_NS * (op_q.size() * 64 + 200));
      $display("Timeout: the run did not finish within %0d clock periods",
               op_q.size() * 64 + 200);
      report_counts();
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire
